// File: common/sdFramePkg.sv
`default_nettype none

package sdFramePkg;

    // ========================================
    // Frame geometry on the CMD line
    // ========================================
    localparam int cmdFrameBits = 48;
    localparam int r1Bits       = 48;
    localparam int r2Bits       = 136;
    localparam int crc7Bits     = 7;
    localparam int cmdIndexW    = 6;

    // Start, transmission, index and argument bits covered by CRC7
    localparam int payloadBits  = cmdFrameBits - crc7Bits - 1;
    localparam int frameCntW    = $clog2(cmdFrameBits);
    localparam int respCntW     = $clog2(r2Bits + 1);

    // App flag in the top bit, command index below
    typedef logic [cmdIndexW:0] sdCmdT;

    localparam sdCmdT cmdGoIdle       = {1'b0, 6'd0};
    localparam sdCmdT cmdAllSendCid   = {1'b0, 6'd2};
    localparam sdCmdT cmdSendRca      = {1'b0, 6'd3};
    localparam sdCmdT cmdSelect       = {1'b0, 6'd7};
    localparam sdCmdT cmdSendIfCond   = {1'b0, 6'd8};
    localparam sdCmdT cmdAppCmd       = {1'b0, 6'd55};
    localparam sdCmdT acmdSetBlkCount = {1'b1, 6'd23};
    localparam sdCmdT acmdSendOpCond  = {1'b1, 6'd41};

    // Argument word, read as an address or as a block count
    typedef union packed {
        struct packed {
            logic [15:0] rca;
            logic [15:0] stuff;
        } rcaView;
        struct packed {
            logic [8:0]  reserved;
            logic [22:0] blockCount;
        } cntView;
    } cmdArgU;

    typedef logic [2:0] sdErrT;

    localparam sdErrT errNone       = 3'd0;
    localparam sdErrT errPreamble   = 3'd1;
    localparam sdErrT errCrc        = 3'd2;
    localparam sdErrT errEndBit     = 3'd3;
    localparam sdErrT errIllegalCmd = 3'd4;
    localparam sdErrT errBadRca     = 3'd5;
    localparam sdErrT errZeroCount  = 3'd6;
    localparam sdErrT errBusy       = 3'd7;

endpackage

`default_nettype wire

// File: common/sdCardPkg.sv
`default_nettype none

package sdCardPkg;

    // ========================================
    // Card identity
    // ========================================
    localparam logic [15:0] cardRca = 16'hAAAA;

    // Complete R2 frame, CRC and end bit included
    localparam logic [135:0] cidValue = 136'h3f_0353_4453_5231_3238_808b_b79d_6601_4677;

    // ========================================
    // R1 words, header plus argument
    // ========================================
    // CRC7 and end bit are appended by the transmitter
    localparam logic [39:0] respSendRca     = 40'h03_aaaa_0520;
    localparam logic [39:0] respSelect      = 40'h07_0000_0700;
    localparam logic [39:0] respIfCond      = 40'h08_0000_01aa;
    localparam logic [39:0] respAppCmd      = 40'h37_0000_0120;

    // OCR with power-up bit clear, then set
    localparam logic [39:0] respOpCondBusy  = 40'h3f_00ff_8080;
    localparam logic [39:0] respOpCondReady = 40'h3f_c1ff_8080;

    // ========================================
    // Timing
    // ========================================
    // Idle cycles between response acceptance and start bit
    localparam int respDelay  = 2;
    localparam int respDelayW = $clog2(respDelay + 1);

endpackage

`default_nettype wire

// File: design/sdCrc7.sv
`timescale 1ns/1ps
`default_nettype none

module sdCrc7 import sdFramePkg::*; (
    input  logic                clk,
    input  logic                rst_,
    input  logic                clear,
    input  logic                shiftEn,
    input  logic                din,
    output logic [crc7Bits-1:0] crc
);

    logic [crc7Bits-1:0] base;
    logic                fb;

    // Clear and first bit may land on the same edge
    assign base = clear ? '0 : crc;
    assign fb   = din ^ base[6];

    // x^7 + x^3 + 1, feedback into bits 0 and 3
    always_ff @(posedge clk) begin
        if (!rst_) begin
            crc <= '0;
        end else if (shiftEn) begin
            crc <= {base[5:3], base[2] ^ fb, base[1:0], fb};
        end else begin
            crc <= base;
        end
    end

endmodule

`default_nettype wire

// File: cmdRx/sdCmdReceiver.sv
`timescale 1ns/1ps
`default_nettype none

module sdCmdReceiver import sdFramePkg::*; (
    input  logic        clk,
    input  logic        rst_,
    input  logic        cmdIn,
    input  logic        cmdOe,
    output logic        frameValid,
    output sdCmdT       frameCmd,
    output logic [31:0] frameArg,
    output sdErrT       frameErr
);

    logic                    active;
    logic [frameCntW-1:0]    bitCnt;
    logic [cmdFrameBits-2:0] shiftReg;
    logic                    startDet;
    logic                    lastBit;
    logic                    crcEn;
    logic [crc7Bits-1:0]     crc;
    sdErrT                   checkErr;

    // Line is ours only while the card is not driving
    assign startDet = !active && !cmdOe && !cmdIn;
    assign lastBit  = active && (bitCnt == frameCntW'(cmdFrameBits - 1));
    assign crcEn    = startDet || (active && bitCnt < frameCntW'(payloadBits));

    sdCrc7 sdCrc7_inst (
        .clk     (clk),
        .rst_    (rst_),
        .clear   (startDet),
        .shiftEn (crcEn),
        .din     (cmdIn),
        .crc     (crc)
    );

    // ========================================
    // Frame checks on the end-bit cycle
    // ========================================
    // shiftReg holds bits 47..1, cmdIn is the end bit
    always_comb begin
        if (shiftReg[cmdFrameBits-2 -: 2] != 2'b01) begin
            checkErr = errPreamble;
        end else if (shiftReg[crc7Bits-1:0] != crc) begin
            checkErr = errCrc;
        end else if (!cmdIn) begin
            checkErr = errEndBit;
        end else begin
            checkErr = errNone;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_) begin
            active     <= 1'b0;
            bitCnt     <= '0;
            frameValid <= 1'b0;
        end else begin
            frameValid <= lastBit;
            if (startDet) begin
                active <= 1'b1;
                bitCnt <= frameCntW'(1);
            end else if (lastBit) begin
                active <= 1'b0;
                bitCnt <= '0;
            end else if (active) begin
                bitCnt <= bitCnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (startDet || active) begin
            shiftReg <= {shiftReg[cmdFrameBits-3:0], cmdIn};
        end
        if (lastBit) begin
            frameCmd <= {1'b0, shiftReg[cmdFrameBits-4 -: cmdIndexW]};
            frameArg <= shiftReg[payloadBits-2 -: 32];
            frameErr <= checkErr;
        end
    end

endmodule

`default_nettype wire

// File: card/sdCmdDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module sdCmdDecoder import sdFramePkg::*; import sdCardPkg::*; (
    input  logic              clk,
    input  logic              rst_,
    input  logic              frameValid,
    input  sdCmdT             frameCmd,
    input  logic [31:0]       frameArg,
    input  sdErrT             frameErr,
    input  logic              respReady,
    output logic              respValid,
    output logic              respLong,
    output logic [r2Bits-1:0] respWord,
    output logic              cmdErr,
    output sdErrT             errCode
);

    logic              appFlag;
    logic              readyFlag;
    logic [15:0]       rcaReg;
    sdCmdT             fullCmd;
    cmdArgU            argU;
    sdErrT             decErr;
    logic              decSend;
    logic              decLong;
    logic [r2Bits-1:0] decResp;
    logic              pending;
    logic              loadResp;

    // Short word left aligned, tail filled with idle ones
    function automatic logic [r2Bits-1:0] shortResp(input logic [payloadBits-1:0] w);
        return {w, {(r2Bits - payloadBits){1'b1}}};
    endfunction

    assign fullCmd  = {appFlag, frameCmd[cmdIndexW-1:0]};
    assign argU     = frameArg;
    assign pending  = respValid && !respReady;
    assign loadResp = frameValid && !pending && decErr == errNone && decSend;

    // ========================================
    // Command decode
    // ========================================
    always_comb begin
        decErr  = errNone;
        decSend = 1'b0;
        decLong = 1'b0;
        decResp = '1;
        if (frameErr != errNone) begin
            decErr = frameErr;
        end else begin
            case (fullCmd)
                cmdGoIdle: begin
                end
                cmdAllSendCid: begin
                    decSend = 1'b1;
                    decLong = 1'b1;
                    decResp = cidValue;
                end
                cmdSendRca: begin
                    decSend = 1'b1;
                    decResp = shortResp(respSendRca);
                end
                cmdSelect: begin
                    if (argU.rcaView.rca != rcaReg) begin
                        decErr = errBadRca;
                    end else begin
                        decSend = 1'b1;
                        decResp = shortResp(respSelect);
                    end
                end
                cmdSendIfCond: begin
                    decSend = 1'b1;
                    decResp = shortResp(respIfCond);
                end
                cmdAppCmd: begin
                    decSend = 1'b1;
                    decResp = shortResp(respAppCmd);
                end
                acmdSetBlkCount: begin
                    if (argU.cntView.blockCount == '0) begin
                        decErr = errZeroCount;
                    end else begin
                        // Same R1 word as CMD3
                        decSend = 1'b1;
                        decResp = shortResp(respSendRca);
                    end
                end
                acmdSendOpCond: begin
                    decSend = 1'b1;
                    decResp = shortResp(readyFlag ? respOpCondReady : respOpCondBusy);
                end
                default: begin
                    decErr = errIllegalCmd;
                end
            endcase
        end
    end

    // ========================================
    // Card state and response register
    // ========================================
    always_ff @(posedge clk) begin
        if (!rst_) begin
            appFlag   <= 1'b0;
            readyFlag <= 1'b0;
            rcaReg    <= '0;
            respValid <= 1'b0;
            cmdErr    <= 1'b0;
            errCode   <= errNone;
        end else begin
            cmdErr <= 1'b0;
            if (respValid && respReady) begin
                respValid <= 1'b0;
            end
            if (frameValid) begin
                if (pending) begin
                    // Response still queued, frame is lost
                    cmdErr  <= 1'b1;
                    errCode <= errBusy;
                end else if (decErr != errNone) begin
                    cmdErr  <= 1'b1;
                    errCode <= decErr;
                    appFlag <= 1'b0;
                end else begin
                    appFlag <= (fullCmd == cmdAppCmd);
                    if (decSend) begin
                        respValid <= 1'b1;
                    end
                    case (fullCmd)
                        cmdGoIdle: begin
                            rcaReg    <= '0;
                            readyFlag <= 1'b0;
                        end
                        cmdSendRca:     rcaReg    <= cardRca;
                        acmdSendOpCond: readyFlag <= 1'b1;
                        default: begin
                        end
                    endcase
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (loadResp) begin
            respWord <= decResp;
            respLong <= decLong;
        end
    end

endmodule

`default_nettype wire

// File: respTx/sdRespTransmitter.sv
`timescale 1ns/1ps
`default_nettype none

module sdRespTransmitter import sdFramePkg::*; import sdCardPkg::*; (
    input  logic              clk,
    input  logic              rst_,
    input  logic              respValid,
    input  logic              respLong,
    input  logic [r2Bits-1:0] respWord,
    output logic              respReady,
    output logic              cmdOut,
    output logic              cmdOe
);

    logic                  waiting;
    logic [respDelayW-1:0] delayCnt;
    logic                  isLong;
    logic [respCntW-1:0]   bitIdx;
    logic [respCntW-1:0]   lastIdx;
    logic [r2Bits-1:0]     shiftReg;
    logic [r2Bits-1:0]     shiftNext;
    logic                  accept;
    logic                  emit;
    logic                  crcSlot;
    logic                  crcEn;
    logic                  txBit;
    logic [crc7Bits-1:0]   crc;

    assign lastIdx   = isLong ? respCntW'(r2Bits) : respCntW'(r1Bits);
    assign respReady = !waiting && !cmdOe;
    assign accept    = respValid && respReady;

    // One bit leaves per emit, starting when the delay runs out
    assign emit    = (waiting && delayCnt == '0) || (cmdOe && bitIdx != lastIdx);
    assign crcSlot = !isLong && bitIdx == respCntW'(payloadBits);
    assign crcEn   = emit && !isLong && bitIdx < respCntW'(payloadBits);

    // ========================================
    // Bit selection
    // ========================================
    // At bit 40 the CRC and end bit replace the register top
    assign txBit     = crcSlot ? crc[crc7Bits-1] : shiftReg[r2Bits-1];
    assign shiftNext = crcSlot ? {crc[crc7Bits-2:0], 1'b1, {(r2Bits - crc7Bits){1'b1}}}
                               : {shiftReg[r2Bits-2:0], 1'b1};

    sdCrc7 sdCrc7_inst (
        .clk     (clk),
        .rst_    (rst_),
        .clear   (accept),
        .shiftEn (crcEn),
        .din     (shiftReg[r2Bits-1]),
        .crc     (crc)
    );

    always_ff @(posedge clk) begin
        if (!rst_) begin
            waiting  <= 1'b0;
            delayCnt <= '0;
            isLong   <= 1'b0;
            bitIdx   <= '0;
            cmdOe    <= 1'b0;
            cmdOut   <= 1'b1;
        end else if (accept) begin
            waiting  <= 1'b1;
            delayCnt <= respDelayW'(respDelay);
            isLong   <= respLong;
            bitIdx   <= '0;
        end else if (emit) begin
            waiting <= 1'b0;
            cmdOe   <= 1'b1;
            cmdOut  <= txBit;
            bitIdx  <= bitIdx + 1'b1;
        end else if (waiting) begin
            delayCnt <= delayCnt - 1'b1;
        end else if (cmdOe) begin
            // Last bit done, release the line
            cmdOe  <= 1'b0;
            cmdOut <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            shiftReg <= respWord;
        end else if (emit) begin
            shiftReg <= shiftNext;
        end
    end

endmodule

`default_nettype wire

// File: design/sdCardTop.sv
`timescale 1ns/1ps
`default_nettype none

module sdCardTop import sdFramePkg::*; (
    input  logic  clk,
    input  logic  rst_,
    input  logic  cmdIn,
    output logic  cmdOut,
    output logic  cmdOe,
    output logic  cmdErr,
    output sdErrT errCode
);

    // Receiver to decoder
    logic        frameValid;
    sdCmdT       frameCmd;
    logic [31:0] frameArg;
    sdErrT       frameErr;

    // Decoder to transmitter
    logic              respValid;
    logic              respLong;
    logic [r2Bits-1:0] respWord;
    logic              respReady;

    sdCmdReceiver sdCmdReceiver_inst (
        .clk        (clk),
        .rst_       (rst_),
        .cmdIn      (cmdIn),
        .cmdOe      (cmdOe),
        .frameValid (frameValid),
        .frameCmd   (frameCmd),
        .frameArg   (frameArg),
        .frameErr   (frameErr)
    );

    sdCmdDecoder sdCmdDecoder_inst (
        .clk        (clk),
        .rst_       (rst_),
        .frameValid (frameValid),
        .frameCmd   (frameCmd),
        .frameArg   (frameArg),
        .frameErr   (frameErr),
        .respReady  (respReady),
        .respValid  (respValid),
        .respLong   (respLong),
        .respWord   (respWord),
        .cmdErr     (cmdErr),
        .errCode    (errCode)
    );

    sdRespTransmitter sdRespTransmitter_inst (
        .clk       (clk),
        .rst_      (rst_),
        .respValid (respValid),
        .respLong  (respLong),
        .respWord  (respWord),
        .respReady (respReady),
        .cmdOut    (cmdOut),
        .cmdOe     (cmdOe)
    );

endmodule

`default_nettype wire

// File: test/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock (
    output logic clk
);

    // Half of the 4 ns period
    localparam int halfPeriod = 2;

    initial begin
        clk = 1'b0;
        forever begin
            #halfPeriod clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// File: test/sdCardModel.svh
`ifndef SD_CARD_MODEL_SVH
`define SD_CARD_MODEL_SVH

// ========================================
// Reference model of the card
// ========================================
logic        modelApp;
logic        modelReady;
logic [15:0] modelRca;

// CRC7 over a 40-bit payload, x^7 + x^3 + 1
function automatic logic [6:0] crc7Of(input logic [39:0] bits);
    logic [6:0] c;
    logic       fb;

    c = '0;
    for (int i = 39; i >= 0; i--) begin
        fb = bits[i] ^ c[6];
        c  = {c[5:0], 1'b0};
        if (fb) begin
            c = c ^ 7'h09;
        end
    end
    return c;
endfunction

// R1 frame left aligned, idle ones behind it
function automatic logic [135:0] shortFrame(input logic [39:0] w);
    return {w, crc7Of(w), 1'b1, {88{1'b1}}};
endfunction

task automatic modelReset();
    modelApp   = 1'b0;
    modelReady = 1'b0;
    modelRca   = '0;
endtask

task automatic predict(
    input  logic [5:0]   idx,
    input  logic [31:0]  arg,
    input  sdErrT        fault,
    output sdErrT        expErr,
    output int           expBits,
    output logic [135:0] expWord
);
    sdCmdT       code;
    logic        nextApp;
    logic        isShort;
    logic [39:0] shortWord;

    code      = {modelApp, idx};
    nextApp   = 1'b0;
    isShort   = 1'b0;
    shortWord = '0;
    expErr    = errNone;
    expBits   = 0;
    expWord   = '1;
    if (fault != errNone) begin
        expErr = fault;
    end else begin
        case (code)
            cmdGoIdle: begin
                modelRca   = '0;
                modelReady = 1'b0;
            end
            cmdAllSendCid: begin
                expBits = r2Bits;
                expWord = cidValue;
            end
            cmdSendRca: begin
                modelRca  = cardRca;
                isShort   = 1'b1;
                shortWord = respSendRca;
            end
            cmdSelect: begin
                if (arg[31:16] != modelRca) begin
                    expErr = errBadRca;
                end else begin
                    isShort   = 1'b1;
                    shortWord = respSelect;
                end
            end
            cmdSendIfCond: begin
                isShort   = 1'b1;
                shortWord = respIfCond;
            end
            cmdAppCmd: begin
                nextApp   = 1'b1;
                isShort   = 1'b1;
                shortWord = respAppCmd;
            end
            acmdSetBlkCount: begin
                // Answered with the CMD3 word
                if (arg[22:0] == '0) begin
                    expErr = errZeroCount;
                end else begin
                    isShort   = 1'b1;
                    shortWord = respSendRca;
                end
            end
            acmdSendOpCond: begin
                isShort    = 1'b1;
                shortWord  = modelReady ? respOpCondReady : respOpCondBusy;
                modelReady = 1'b1;
            end
            default: begin
                expErr = errIllegalCmd;
            end
        endcase
    end
    if (isShort) begin
        expBits = r1Bits;
        expWord = shortFrame(shortWord);
    end
    // App prefix lasts one frame
    modelApp = nextApp;
endtask

`endif

// File: test/sdCardTb.sv
`timescale 1ns/1ps
`default_nettype none

module sdCardTb import sdFramePkg::*; import sdCardPkg::*; ();

    // ========================================
    // Run length
    // ========================================
    localparam int directedFrames = 17;
    localparam int randomFrames   = 200;
    localparam int idleGap        = 4;
    localparam int watchLimit     = 12;
    localparam int respStart      = 5;
    localparam int frameCycles    = cmdFrameBits + watchLimit + r2Bits + idleGap + 2;
    localparam int timeoutCycles  = (directedFrames + randomFrames) * frameCycles + 200;

    logic  clk;
    logic  rst_;
    logic  cmdIn;
    logic  cmdOut;
    logic  cmdOe;
    logic  cmdErr;
    sdErrT errCode;

    int seed     = 32'h7057_a9c1;
    int cycleCnt = 0;

    `include "sdCardModel.svh"

    tbClock tbClock_inst (
        .clk (clk)
    );

    sdCardTop sdCardTop_inst (
        .clk     (clk),
        .rst_    (rst_),
        .cmdIn   (cmdIn),
        .cmdOut  (cmdOut),
        .cmdOe   (cmdOe),
        .cmdErr  (cmdErr),
        .errCode (errCode)
    );

    always @(posedge clk) begin
        cycleCnt = cycleCnt + 1;
        if (cycleCnt > timeoutCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
            $display("Verification failed");
            $fatal(1, "Simulation stopped by the cycle limit");
        end
    end

    task automatic checkVal(input string sigName, input logic [135:0] got,
                            input logic [135:0] exp);
        if (got !== exp) begin
            $display("error: time %0t signal %s got %0h expected %0h",
                     $time, sigName, got, exp);
            $display("Verification failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic idleCheck(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            checkVal("cmdOe", cmdOe, 1'b0);
            checkVal("cmdErr", cmdErr, 1'b0);
            checkVal("cmdOut", cmdOut, 1'b1);
        end
    endtask

    // ========================================
    // One command, driven and checked
    // ========================================
    task automatic sendCommand(input logic [5:0] idx, input logic [31:0] arg,
                               input sdErrT fault);
        logic [47:0]  frame;
        logic [135:0] expWord;
        logic [135:0] gotWord;
        sdErrT        expErr;
        sdErrT        gotCode;
        int           expBits;
        int           errAt;
        int           oeAt;
        int           bitPos;

        predict(idx, arg, fault, expErr, expBits, expWord);
        frame = {2'b01, idx, arg, crc7Of({2'b01, idx, arg}), 1'b1};
        case (fault)
            errPreamble: frame[46] = 1'b0;
            errEndBit:   frame[0] = 1'b0;
            errCrc: begin
                bitPos        = 1 + $unsigned($random(seed)) % 7;
                frame[bitPos] = ~frame[bitPos];
            end
            default: begin
            end
        endcase
        for (int i = cmdFrameBits - 1; i >= 0; i--) begin
            @(negedge clk);
            cmdIn = frame[i];
        end

        // d counts rising edges after the end bit
        errAt   = -1;
        oeAt    = -1;
        gotCode = errNone;
        for (int d = 0; d < watchLimit; d++) begin
            @(negedge clk);
            cmdIn = 1'b1;
            if (cmdErr && errAt < 0) begin
                errAt   = d;
                gotCode = errCode;
            end
            if (cmdOe) begin
                oeAt = d;
                break;
            end
        end
        checkVal("cmdErr delay", errAt, (expErr != errNone) ? 1 : -1);
        checkVal("errCode", gotCode, expErr);
        checkVal("cmdOe start", oeAt, (expBits != 0) ? respStart : -1);

        if (expBits != 0) begin
            gotWord             = '1;
            gotWord[r2Bits - 1] = cmdOut;
            for (int i = 1; i < expBits; i++) begin
                @(negedge clk);
                checkVal("cmdOe", cmdOe, 1'b1);
                gotWord[r2Bits - 1 - i] = cmdOut;
            end
            @(negedge clk);
            checkVal("cmdOe release", cmdOe, 1'b0);
            checkVal("cmdOut idle", cmdOut, 1'b1);
            checkVal("response", gotWord, expWord);
        end
        repeat (idleGap) @(negedge clk);
    endtask

    task automatic sendRandom();
        logic [31:0] r;
        logic [31:0] f;
        logic [31:0] arg;
        logic [5:0]  idx;
        sdErrT       fault;

        r   = $random(seed);
        f   = $random(seed);
        arg = $random(seed);
        case (r[3:0])
            4'd0:             idx = 6'd0;
            4'd1:             idx = 6'd2;
            4'd2:             idx = 6'd3;
            4'd3, 4'd4:       idx = 6'd7;
            4'd5:             idx = 6'd8;
            4'd6, 4'd7, 4'd8: idx = 6'd55;
            4'd9, 4'd10:      idx = 6'd41;
            4'd11:            idx = 6'd23;
            default:          idx = r[9:4];
        endcase
        // Half of the CMD7 frames carry the current address
        if (idx == 6'd7 && r[10]) begin
            arg[31:16] = modelRca;
        end
        if (idx == 6'd23 && r[11]) begin
            arg[22:0] = '0;
        end
        case (f[3:0])
            4'd0:    fault = errCrc;
            4'd1:    fault = errPreamble;
            4'd2:    fault = errEndBit;
            default: fault = errNone;
        endcase
        sendCommand(idx, arg, fault);
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        cmdIn = 1'b1;
        rst_  = 1'b0;
        modelReset();
        repeat (8) @(negedge clk);
        rst_ = 1'b1;
        idleCheck(20);

        sendCommand(6'd0, 32'h0, errNone);
        sendCommand(6'd8, 32'h0000_01aa, errNone);
        // Power-up handshake, busy then ready
        sendCommand(6'd55, 32'h0, errNone);
        sendCommand(6'd41, 32'h40ff_8000, errNone);
        sendCommand(6'd55, 32'h0, errNone);
        sendCommand(6'd41, 32'h40ff_8000, errNone);
        sendCommand(6'd2, 32'h0, errNone);
        sendCommand(6'd3, 32'h0, errNone);
        sendCommand(6'd7, 32'h1234_0000, errNone);
        sendCommand(6'd7, {cardRca, 16'h0}, errNone);
        sendCommand(6'd55, {cardRca, 16'h0}, errNone);
        sendCommand(6'd23, 32'h0, errNone);
        sendCommand(6'd41, 32'h40ff_8000, errNone);
        // Framing faults
        sendCommand(6'd8, 32'h0000_01aa, errCrc);
        sendCommand(6'd8, 32'h0000_01aa, errPreamble);
        sendCommand(6'd8, 32'h0000_01aa, errEndBit);
        sendCommand(6'd63, 32'h0, errNone);

        repeat (randomFrames) begin
            sendRandom();
        end

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+test
common/sdFramePkg.sv
common/sdCardPkg.sv
design/sdCrc7.sv
cmdRx/sdCmdReceiver.sv
card/sdCmdDecoder.sv
respTx/sdRespTransmitter.sv
design/sdCardTop.sv
test/tbClock.sv
test/sdCardTb.sv

// File: run.sh
#!/bin/sh
# Build and run the SD card testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f verilog.f --top-module sdCardTb -Mdir obj_dir

# The simulator exits nonzero on a failed check, the search below decides
output=$(./obj_dir/VsdCardTb 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Verification passed"; then
    exit 0
fi
exit 1
